// File: Makefile
VERILATOR   ?= verilator
TOP         ?= tb_pixel_shader
RTL_TOP     ?= pixel_shader
SEED        ?= 36122
FILELIST    ?= project.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: design/credit_queue.sv
`timescale 1ns/1ns
`include "shader_config.svh"

module credit_queue (
    input  logic                clk,
    input  logic                rst_in,
    input  logic                wr_valid,
    input  logic [`COLOR_W-1:0] wr_color,
    input  logic                out_credit,
    output logic                in_credit,
    output logic                out_valid,
    output logic [`COLOR_W-1:0] out_color
);

    localparam int DEPTH    = `QUEUE_DEPTH;
    localparam int PTR_W    = $clog2(DEPTH);
    localparam int CNT_W    = $clog2(DEPTH + 1);
    localparam int CREDIT_W = 16; // sink may run far ahead of us

    logic [`COLOR_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic [CREDIT_W-1:0] sink_credits;
    logic                pop;

    // oldest entry leaves only when the sink has room for it
    assign pop = (count != '0) && (sink_credits != '0);

    always_ff @(posedge clk) begin
        if (wr_valid)
            mem[wr_ptr] <= wr_color;
    end

    always_ff @(posedge clk) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_valid)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
    end

    // occupancy and sink credits, both can move up and down in one cycle
    always_ff @(posedge clk) begin
        if (rst_in) begin
            count        <= '0;
            sink_credits <= '0;
        end else begin
            count        <= count + CNT_W'(wr_valid) - CNT_W'(pop);
            sink_credits <= sink_credits + CREDIT_W'(out_credit) - CREDIT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_in) begin
            out_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            out_valid <= pop;
            in_credit <= pop; // freed slot goes back to the source
        end
    end

    always_ff @(posedge clk) begin
        if (pop)
            out_color <= mem[rd_ptr];
    end

endmodule

// File: design/magnitude_stage.sv
`timescale 1ns/1ns
`include "shader_config.svh"

module magnitude_stage (
    input  logic                   clk,
    input  logic                   rst_in,
    input  logic                   in_valid,
    input  shader_pkg::normal_t    normal,
    output logic                   out_valid,
    output shader_pkg::magnitude_t mag
);

    logic signed [`MAG_W-1:0] nx_sq;
    logic signed [`MAG_W-1:0] ny_sq;
    logic signed [`MAG_W-1:0] nz_sq;

    // squares are never negative, width covers three of them summed
    assign nx_sq = normal.nx * normal.nx;
    assign ny_sq = normal.ny * normal.ny;
    assign nz_sq = normal.nz * normal.nz;

    always_ff @(posedge clk) begin
        if (rst_in) out_valid <= 1'b0;
        else        out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        mag.nz_sq       <= nz_sq;                // dot with light, squared
        mag.mag_sq      <= nx_sq + ny_sq + nz_sq;
        mag.back_facing <= normal.nz[`NORM_W-1]; // nz < 0
    end

endmodule

// File: design/normal_stage.sv
`timescale 1ns/1ns
`include "shader_config.svh"

module normal_stage (
    input  logic                clk,
    input  logic                rst_in,
    input  logic                in_valid,
    input  shader_pkg::vertex_t v0,
    input  shader_pkg::vertex_t v1,
    input  shader_pkg::vertex_t v2,
    output logic                out_valid,
    output shader_pkg::normal_t normal
);

    // edge a = v1 - v0 = (d, e, f), edge b = v2 - v0 = (g, h, i)
    logic signed [`EDGE_W-1:0] d;
    logic signed [`EDGE_W-1:0] e;
    logic signed [`EDGE_W-1:0] f;
    logic signed [`EDGE_W-1:0] g;
    logic signed [`EDGE_W-1:0] h;
    logic signed [`EDGE_W-1:0] i;
    logic                      edge_valid;

    always_ff @(posedge clk) begin
        if (rst_in) begin
            edge_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            edge_valid <= in_valid;
            out_valid  <= edge_valid;
        end
    end

    // first level, edge vectors out of vertex 0
    always_ff @(posedge clk) begin
        d <= v1.x - v0.x;
        e <= v1.y - v0.y;
        f <= v1.z - v0.z;
        g <= v2.x - v0.x;
        h <= v2.y - v0.y;
        i <= v2.z - v0.z;
    end

    // second level, cross product a x b
    // products are evaluated at NORM_W so nothing overflows
    always_ff @(posedge clk) begin
        normal.nx <= e * i - f * h;
        normal.ny <= f * g - d * i;
        normal.nz <= d * h - e * g; // sign of this decides back-facing
    end

endmodule

// File: design/pixel_shader.sv
`timescale 1ns/1ns
`include "shader_config.svh"

module pixel_shader (
    input  logic                clk,
    input  logic                rst_in,
    input  logic                tri_valid,
    input  shader_pkg::vertex_t v0,
    input  shader_pkg::vertex_t v1,
    input  shader_pkg::vertex_t v2,
    input  logic                out_credit,
    output logic                in_credit,
    output logic                out_valid,
    output logic [`COLOR_W-1:0] out_color
);

    logic                   norm_valid;
    shader_pkg::normal_t    normal;
    logic                   mag_valid;
    shader_pkg::magnitude_t mag;
    logic                   shade_valid;
    shader_pkg::shade_t     shade;
    logic                   color_valid;
    logic [`COLOR_W-1:0]    color;

    normal_stage u_normal (
        .clk       (clk),
        .rst_in    (rst_in),
        .in_valid  (tri_valid),
        .v0        (v0),
        .v1        (v1),
        .v2        (v2),
        .out_valid (norm_valid),
        .normal    (normal)
    );

    magnitude_stage u_magnitude (
        .clk       (clk),
        .rst_in    (rst_in),
        .in_valid  (norm_valid),
        .normal    (normal),
        .out_valid (mag_valid),
        .mag       (mag)
    );

    shade_index_stage u_shade_index (
        .clk       (clk),
        .rst_in    (rst_in),
        .in_valid  (mag_valid),
        .mag       (mag),
        .out_valid (shade_valid),
        .shade     (shade)
    );

    shade_lut_stage u_shade_lut (
        .clk       (clk),
        .rst_in    (rst_in),
        .in_valid  (shade_valid),
        .shade     (shade),
        .out_valid (color_valid),
        .color     (color)
    );

    // results land here 5 cycles after tri_valid
    credit_queue u_queue (
        .clk        (clk),
        .rst_in     (rst_in),
        .wr_valid   (color_valid),
        .wr_color   (color),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_color  (out_color)
    );

endmodule

// File: design/shade_index_stage.sv
`timescale 1ns/1ns
`include "shader_config.svh"

module shade_index_stage (
    input  logic                   clk,
    input  logic                   rst_in,
    input  logic                   in_valid,
    input  shader_pkg::magnitude_t mag,
    output logic                   out_valid,
    output shader_pkg::shade_t     shade
);

    localparam int IDX_W = $clog2(`SHADE_LEVELS);

    logic [`MAG_W+3:0] nz_sq_x16;  // 16 * nz^2
    logic [`MAG_W+3:0] multiple;   // running k * |n|^2
    logic [IDX_W-1:0]  count;

    // count k in 1..15 with k*|n|^2 <= 16*nz^2, no divider needed
    always_comb begin
        nz_sq_x16 = {mag.nz_sq, 4'b0000};
        multiple  = '0;
        count     = '0;
        for (int k = 1; k < `SHADE_LEVELS; k++) begin
            multiple = multiple + mag.mag_sq;
            if (multiple <= nz_sq_x16)
                count = count + 1'b1;
        end
        // zero-area triangle has no direction at all
        if (mag.mag_sq == '0)
            count = '0;
    end

    always_ff @(posedge clk) begin
        if (rst_in) out_valid <= 1'b0;
        else        out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        shade.index       <= count;
        shade.back_facing <= mag.back_facing;
    end

endmodule

// File: design/shade_lut_stage.sv
`timescale 1ns/1ns
`include "shader_config.svh"

module shade_lut_stage (
    input  logic                     clk,
    input  logic                     rst_in,
    input  logic                     in_valid,
    input  shader_pkg::shade_t       shade,
    output logic                     out_valid,
    output logic [`COLOR_W-1:0]      color
);

    // grey ramp, light falls off faster at grazing angles
    localparam logic [`COLOR_W-1:0] GREY_LUT [`SHADE_LEVELS] = '{
        8'd0,   8'd20,  8'd40,  8'd60,
        8'd78,  8'd96,  8'd114, 8'd130,
        8'd146, 8'd162, 8'd178, 8'd194,
        8'd210, 8'd226, 8'd242, 8'd255
    };

    localparam logic [`COLOR_W-1:0] BACK_COLOR = '1; // hidden faces go white

    always_ff @(posedge clk) begin
        if (rst_in) out_valid <= 1'b0;
        else        out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (shade.back_facing)
            color <= BACK_COLOR;
        else
            color <= GREY_LUT[shade.index];
    end

endmodule

// File: design/shader_config.svh
`ifndef SHADER_CONFIG_SVH
`define SHADER_CONFIG_SVH

// signed vertex coordinate
`define COORD_W 10

// edge component, one bit of growth from the subtraction
`define EDGE_W 11

// cross product component, two products and a difference
`define NORM_W 23

// sum of three squared normal components
`define MAG_W 48

// output queue entries, also the source's initial credit count
`define QUEUE_DEPTH 8

// grey table size
`define SHADE_LEVELS 16

// grey level width
`define COLOR_W 8

`endif

// File: design/shader_pkg.sv
`include "shader_config.svh"

package shader_pkg;

    // one triangle corner in screen space
    typedef struct packed {
        logic signed [`COORD_W-1:0] x;
        logic signed [`COORD_W-1:0] y;
        logic signed [`COORD_W-1:0] z;
    } vertex_t;

    // surface normal, cross product of the two edges
    typedef struct packed {
        logic signed [`NORM_W-1:0] nx;
        logic signed [`NORM_W-1:0] ny;
        logic signed [`NORM_W-1:0] nz;
    } normal_t;

    // light is (0,0,-1), so only nz enters the dot product
    typedef struct packed {
        logic [`MAG_W-1:0] nz_sq;
        logic [`MAG_W-1:0] mag_sq;
        logic              back_facing;
    } magnitude_t;

    typedef struct packed {
        logic [$clog2(`SHADE_LEVELS)-1:0] index; // floor(16*cos^2), capped
        logic                             back_facing;
    } shade_t;

endpackage

// File: project.f
+incdir+design
design/shader_pkg.sv
design/normal_stage.sv
design/magnitude_stage.sv
design/shade_index_stage.sv
design/shade_lut_stage.sv
design/credit_queue.sv
design/pixel_shader.sv
verif/tb_pixel_shader.sv

// File: verif/tb_pixel_shader.sv
`timescale 1ns/1ns
`include "shader_config.svh"

module tb_pixel_shader #(
    parameter int SEED = 32'h8d1a
);

    localparam int NUM_TRI        = 200;
    localparam int TIMEOUT_CYCLES = NUM_TRI * 40;
    localparam logic [`COLOR_W-1:0] GREY_REF [16] = '{
        8'd0,   8'd20,  8'd40,  8'd60,  8'd78,  8'd96,  8'd114, 8'd130,
        8'd146, 8'd162, 8'd178, 8'd194, 8'd210, 8'd226, 8'd242, 8'd255
    };

    logic                clk;
    logic                rst_in;
    logic                tri_valid;
    shader_pkg::vertex_t v0;
    shader_pkg::vertex_t v1;
    shader_pkg::vertex_t v2;
    logic                out_credit;
    logic                in_credit;
    logic                out_valid;
    logic [`COLOR_W-1:0] out_color;

    integer seed;
    int     src_credits;    // credits the source still holds
    int     sent;
    int     delivered;
    int     credits_given;  // out_credit pulses driven so far
    int     sink_left;      // cycles left in this sink phase
    bit     sink_hold;
    int     n_back;
    int     n_degen;
    int     n_top;
    int     n_full;         // sends that spent the last credit
    logic [`COLOR_W-1:0] exp_q [$];
    string               name_q [$];

    pixel_shader UUT (
        .clk        (clk),
        .rst_in     (rst_in),
        .tri_valid  (tri_valid),
        .v0         (v0),
        .v1         (v1),
        .v2         (v2),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_color  (out_color)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // normal of (v1-v0) x (v2-v0) at full precision
    function automatic void normal_of(input shader_pkg::vertex_t a, input shader_pkg::vertex_t b,
                                      input shader_pkg::vertex_t c, output longint nx,
                                      output longint ny, output longint nz);
        longint d, e, f, g, h, i;
        d  = longint'(b.x) - longint'(a.x);
        e  = longint'(b.y) - longint'(a.y);
        f  = longint'(b.z) - longint'(a.z);
        g  = longint'(c.x) - longint'(a.x);
        h  = longint'(c.y) - longint'(a.y);
        i  = longint'(c.z) - longint'(a.z);
        nx = e * i - f * h;
        ny = f * g - d * i;
        nz = d * h - e * g;
    endfunction

    // index is floor(16 cos^2) by plain division and capped at 15
    function automatic logic [`COLOR_W-1:0] color_of(input longint nx, ny, nz);
        longint mag_sq;
        longint idx;
        if (nz < 0)
            return 8'd255;
        mag_sq = nx * nx + ny * ny + nz * nz;
        if (mag_sq == 0)
            return GREY_REF[0];
        idx = (16 * nz * nz) / mag_sq;
        return GREY_REF[idx > 15 ? 15 : idx];
    endfunction

    function automatic shader_pkg::vertex_t random_vertex(input int shift);
        logic [31:0]         r;
        shader_pkg::vertex_t v;
        r   = $random(seed);
        v.x = r[9:0];
        v.y = r[19:10];
        v.z = r[29:20];
        v.x = v.x >>> shift; // shrink range but keep sign
        v.y = v.y >>> shift;
        v.z = v.z >>> shift;
        return v;
    endfunction

    function automatic shader_pkg::vertex_t offset_vertex(input shader_pkg::vertex_t p,
                                                          input shader_pkg::vertex_t d,
                                                          input int k);
        shader_pkg::vertex_t v;
        v.x = `COORD_W'(int'(p.x) + k * int'(d.x));
        v.y = `COORD_W'(int'(p.y) + k * int'(d.y));
        v.z = `COORD_W'(int'(p.z) + k * int'(d.z));
        return v;
    endfunction

    task automatic send_triangle();
        shader_pkg::vertex_t a;
        shader_pkg::vertex_t b;
        shader_pkg::vertex_t c;
        shader_pkg::vertex_t dir;
        longint              nx, ny, nz;
        logic [`COLOR_W-1:0] want;
        string               name;
        int                  kind;
        kind = $unsigned($random(seed)) % 8;
        a    = random_vertex(0);
        b    = random_vertex(0);
        c    = random_vertex(0);
        name = "random";
        case (kind)
            0: begin
                name = "repeated";
                c    = b;
            end
            1: begin
                name = "collinear"; // three points on one line
                a    = random_vertex(1);
                dir  = random_vertex(4);
                b    = offset_vertex(a, dir, 1);
                c    = offset_vertex(a, dir, 2);
            end
            2: begin
                name = "xy_plane";
                b.z  = a.z;
                c.z  = a.z;
            end
            default: ;
        endcase
        normal_of(a, b, c, nx, ny, nz);
        // flat triangles are turned to face the viewer
        if (kind == 2 && nz < 0) begin
            dir = b;
            b   = c;
            c   = dir;
            normal_of(a, b, c, nx, ny, nz);
        end
        want = color_of(nx, ny, nz);
        if (nz < 0)
            n_back++;
        else if (nx == 0 && ny == 0 && nz == 0)
            n_degen++;
        else if (want == 8'd255)
            n_top++;
        exp_q.push_back(want);
        name_q.push_back(name);
        v0        <= a;
        v1        <= b;
        v2        <= c;
        tri_valid <= 1'b1;
        src_credits--;
        if (src_credits == 0)
            n_full++;
        sent++;
    endtask

    // sink alternates long withholding stretches with busy stretches
    task automatic drive_sink();
        bit give;
        if (sink_left == 0) begin
            sink_hold = !sink_hold;
            sink_left = 20 + $unsigned($random(seed)) % 41;
        end
        sink_left--;
        give = !sink_hold && (($random(seed) & 3) != 0);
        out_credit <= give;
        if (give)
            credits_given++;
    endtask

    always @(negedge clk) begin : check_outputs
        logic [`COLOR_W-1:0] want;
        string               name;
        if (!rst_in) begin
            if (in_credit)
                src_credits++;
            assert (src_credits <= `QUEUE_DEPTH)
                else stop_with_failure("source holds more credits than the queue has entries");
            assert (in_credit == out_valid)
                else stop_with_failure("in_credit and out_valid did not pulse together");
            if (out_valid) begin
                delivered++;
                assert (exp_q.size() > 0)
                    else stop_with_failure("out_valid fired with no triangle outstanding");
                assert (delivered <= credits_given)
                    else stop_with_failure("out_valid fired without a sink credit held");
                want = exp_q.pop_front();
                name = name_q.pop_front();
                assert (out_color == want)
                    else stop_with_failure($sformatf(
                        "Mismatch in %s triangle %0d: expected %0d, actual %0d",
                        name, delivered, want, out_color));
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        stop_with_failure($sformatf("timeout: only %0d of %0d results arrived in %0d cycles",
                                    delivered, NUM_TRI, TIMEOUT_CYCLES));
    end

    initial begin : stimulus
        seed          = SEED;
        clk           = 1'b0;
        rst_in        = 1'b1;
        tri_valid     = 1'b0;
        v0            = '0;
        v1            = '0;
        v2            = '0;
        out_credit    = 1'b0;
        src_credits   = `QUEUE_DEPTH;
        sent          = 0;
        delivered     = 0;
        credits_given = 0;
        sink_left     = 0;
        sink_hold     = 1'b0; // first phase flips to withholding
        n_back        = 0;
        n_degen       = 0;
        n_top         = 0;
        n_full        = 0;
        repeat (2) @(posedge clk);
        rst_in <= 1'b0;
        while (delivered < NUM_TRI) begin
            @(posedge clk);
            drive_sink();
            if (sent < NUM_TRI && src_credits > 0 && ($random(seed) & 3) != 0)
                send_triangle();
            else
                tri_valid <= 1'b0;
        end
        out_credit <= 1'b0;
        tri_valid  <= 1'b0;
        repeat (4) @(negedge clk); // room for a stray extra result
        if (n_back > 0 && n_degen > 0 && n_top > 0 && n_full > 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_with_failure("stimulus never reached one of the corner cases");
        end
    end

endmodule
